/* common/raster_macros.svh */
`ifndef RASTER_MACROS_SVH
`define RASTER_MACROS_SVH

// One word for coordinates and results
`define RASTER_DATA_WIDTH 32

// Vertex coordinates are Q16.16
`define RASTER_FRAC_BITS 16

// Area and edge values are Q28.4
`define RASTER_AREA_FRAC_BITS 4

// Screen size in whole pixels
`define RASTER_SCREEN_W 640
`define RASTER_SCREEN_H 360

`endif

/* common/raster_pkg.sv */
`include "raster_macros.svh"

package raster_pkg;

    // Signed Q16.16 screen coordinate
    typedef logic signed [`RASTER_DATA_WIDTH-1:0] coord_t;

    // Signed Q28.4 area or edge value
    typedef logic signed [`RASTER_DATA_WIDTH-1:0] area_t;

    // Full product of two coordinates, Q32.32
    typedef logic signed [2*`RASTER_DATA_WIDTH-1:0] wide_t;

    // Setup sequence, one edge-unit pass per compute state
    typedef enum logic [2:0] {
        IDLE,
        AREA,
        EDGE0,
        EDGE1,
        EDGE2,
        DONE
    } setup_state_e;

endpackage

/* hw/bbox_clamp.sv */
`timescale 1ns/1ps

`include "raster_macros.svh"

module bbox_clamp (
    input  raster_pkg::coord_t i_v0_x,
    input  raster_pkg::coord_t i_v0_y,
    input  raster_pkg::coord_t i_v1_x,
    input  raster_pkg::coord_t i_v1_y,
    input  raster_pkg::coord_t i_v2_x,
    input  raster_pkg::coord_t i_v2_y,
    output raster_pkg::coord_t o_min_x,
    output raster_pkg::coord_t o_min_y,
    output raster_pkg::coord_t o_max_x,
    output raster_pkg::coord_t o_max_y,
    output logic               o_nonempty
);
    import raster_pkg::*;

    // Screen corners in Q16.16
    localparam coord_t SCREEN_MIN   = '0;
    localparam coord_t SCREEN_MAX_X = coord_t'(`RASTER_SCREEN_W) << `RASTER_FRAC_BITS;
    localparam coord_t SCREEN_MAX_Y = coord_t'(`RASTER_SCREEN_H) << `RASTER_FRAC_BITS;

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    coord_t lo_x;
    coord_t lo_y;
    coord_t hi_x;
    coord_t hi_y;

    assign lo_x = min3(i_v0_x, i_v1_x, i_v2_x);
    assign lo_y = min3(i_v0_y, i_v1_y, i_v2_y);
    assign hi_x = max3(i_v0_x, i_v1_x, i_v2_x);
    assign hi_y = max3(i_v0_y, i_v1_y, i_v2_y);

    assign o_min_x = (lo_x < SCREEN_MIN) ? SCREEN_MIN : lo_x;
    assign o_min_y = (lo_y < SCREEN_MIN) ? SCREEN_MIN : lo_y;
    assign o_max_x = (hi_x > SCREEN_MAX_X) ? SCREEN_MAX_X : hi_x;
    assign o_max_y = (hi_y > SCREEN_MAX_Y) ? SCREEN_MAX_Y : hi_y;

    // Off-screen triangles end up with min past max after the clamp
    assign o_nonempty = (o_min_x < o_max_x) && (o_min_y < o_max_y);

endmodule

/* hw/edge_function_unit.sv */
`timescale 1ns/1ps

module edge_function_unit (
    input  raster_pkg::coord_t i_a_x,
    input  raster_pkg::coord_t i_a_y,
    input  raster_pkg::coord_t i_b_x,
    input  raster_pkg::coord_t i_b_y,
    input  raster_pkg::coord_t i_p_x,
    input  raster_pkg::coord_t i_p_y,
    output raster_pkg::wide_t  o_value,
    output raster_pkg::coord_t o_step_x,
    output raster_pkg::coord_t o_step_y
);
    import raster_pkg::*;

    coord_t pa_x;
    coord_t pa_y;
    coord_t ba_x;
    coord_t ba_y;
    wide_t  prod_x;
    wide_t  prod_y;

    assign pa_x = i_p_x - i_a_x;
    assign pa_y = i_p_y - i_a_y;
    assign ba_x = i_b_x - i_a_x;
    assign ba_y = i_b_y - i_a_y;

    // Sign-extend before multiplying so the product keeps all 64 bits
    assign prod_x = wide_t'(pa_x) * wide_t'(ba_y);
    assign prod_y = wide_t'(pa_y) * wide_t'(ba_x);
    assign o_value = prod_x - prod_y;

    // Change of the edge function for one pixel step
    assign o_step_x = ba_y;
    assign o_step_y = -ba_x;

endmodule

/* hw/setup_ctrl.sv */
`timescale 1ns/1ps

`include "raster_macros.svh"

module setup_ctrl (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_valid,
    output logic               o_ready,
    input  raster_pkg::coord_t i_v0_x,
    input  raster_pkg::coord_t i_v0_y,
    input  raster_pkg::coord_t i_v1_x,
    input  raster_pkg::coord_t i_v1_y,
    input  raster_pkg::coord_t i_v2_x,
    input  raster_pkg::coord_t i_v2_y,
    output raster_pkg::coord_t o_edge_a_x,
    output raster_pkg::coord_t o_edge_a_y,
    output raster_pkg::coord_t o_edge_b_x,
    output raster_pkg::coord_t o_edge_b_y,
    output raster_pkg::coord_t o_edge_p_x,
    output raster_pkg::coord_t o_edge_p_y,
    input  raster_pkg::wide_t  i_edge_value,
    input  raster_pkg::coord_t i_edge_step_x,
    input  raster_pkg::coord_t i_edge_step_y,
    input  raster_pkg::coord_t i_bb_min_x,
    input  raster_pkg::coord_t i_bb_min_y,
    input  raster_pkg::coord_t i_bb_max_x,
    input  raster_pkg::coord_t i_bb_max_y,
    input  logic               i_bb_nonempty,
    output raster_pkg::coord_t o_vtx0_x,
    output raster_pkg::coord_t o_vtx0_y,
    output raster_pkg::coord_t o_vtx1_x,
    output raster_pkg::coord_t o_vtx1_y,
    output raster_pkg::coord_t o_vtx2_x,
    output raster_pkg::coord_t o_vtx2_y,
    output logic               o_valid,
    input  logic               i_ready,
    output logic               o_culled,
    output raster_pkg::coord_t o_bb_min_x,
    output raster_pkg::coord_t o_bb_min_y,
    output raster_pkg::coord_t o_bb_max_x,
    output raster_pkg::coord_t o_bb_max_y,
    output raster_pkg::area_t  o_area,
    output raster_pkg::area_t  o_edge0_val,
    output raster_pkg::area_t  o_edge1_val,
    output raster_pkg::area_t  o_edge2_val,
    output raster_pkg::area_t  o_edge0_dx,
    output raster_pkg::area_t  o_edge0_dy,
    output raster_pkg::area_t  o_edge1_dx,
    output raster_pkg::area_t  o_edge1_dy,
    output raster_pkg::area_t  o_edge2_dx,
    output raster_pkg::area_t  o_edge2_dy
);
    import raster_pkg::*;

    // Q32.32 product down to Q28.4, Q16.16 step down to Q28.4
    localparam int PROD_SHIFT = 2 * `RASTER_FRAC_BITS - `RASTER_AREA_FRAC_BITS;
    localparam int STEP_SHIFT = `RASTER_FRAC_BITS - `RASTER_AREA_FRAC_BITS;

    // About one pixel of area
    localparam area_t CULL_AREA = area_t'(1 << `RASTER_AREA_FRAC_BITS);

    function automatic area_t to_area(input wide_t v);
        return area_t'(v[PROD_SHIFT +: `RASTER_DATA_WIDTH]);
    endfunction

    function automatic area_t to_step(input coord_t s);
        return area_t'(s >>> STEP_SHIFT);
    endfunction

    setup_state_e state;
    setup_state_e state_nxt;

    coord_t r_v0_x;
    coord_t r_v0_y;
    coord_t r_v1_x;
    coord_t r_v1_y;
    coord_t r_v2_x;
    coord_t r_v2_y;
    logic   r_bb_nonempty;
    logic   cull;

    assign o_vtx0_x = r_v0_x;
    assign o_vtx0_y = r_v0_y;
    assign o_vtx1_x = r_v1_x;
    assign o_vtx1_y = r_v1_y;
    assign o_vtx2_x = r_v2_x;
    assign o_vtx2_y = r_v2_y;

    assign o_ready = (state == IDLE);

    // Small or clockwise area, or nothing left on screen
    assign cull = (o_area <= CULL_AREA) || !r_bb_nonempty;

    // Operands of the shared edge unit
    always_comb begin
        o_edge_a_x = r_v0_x;
        o_edge_a_y = r_v0_y;
        o_edge_b_x = r_v1_x;
        o_edge_b_y = r_v1_y;
        o_edge_p_x = o_bb_min_x;
        o_edge_p_y = o_bb_min_y;
        case (state)
            AREA: begin
                o_edge_p_x = r_v2_x;
                o_edge_p_y = r_v2_y;
            end
            EDGE1: begin
                o_edge_a_x = r_v1_x;
                o_edge_a_y = r_v1_y;
                o_edge_b_x = r_v2_x;
                o_edge_b_y = r_v2_y;
            end
            EDGE2: begin
                o_edge_a_x = r_v2_x;
                o_edge_a_y = r_v2_y;
                o_edge_b_x = r_v0_x;
                o_edge_b_y = r_v0_y;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (i_valid) state_nxt = AREA;
            AREA:    state_nxt = EDGE0;
            EDGE0:   state_nxt = cull ? DONE : EDGE1;
            EDGE1:   state_nxt = EDGE2;
            EDGE2:   state_nxt = DONE;
            DONE:    if (o_valid && i_ready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= IDLE;
            o_valid  <= 1'b0;
            o_culled <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == DONE && !o_valid) begin
                o_valid <= 1'b1;
            end else if (o_valid && i_ready) begin
                o_valid <= 1'b0;
            end
            if (state == IDLE && i_valid) begin
                o_culled <= 1'b0;
            end else if (state == EDGE0) begin
                o_culled <= cull;
            end
        end
    end

    // Result registers stay put from DONE until the beat transfers
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (i_valid) begin
                    r_v0_x <= i_v0_x;
                    r_v0_y <= i_v0_y;
                    r_v1_x <= i_v1_x;
                    r_v1_y <= i_v1_y;
                    r_v2_x <= i_v2_x;
                    r_v2_y <= i_v2_y;
                end
            end
            AREA: begin
                o_area        <= to_area(i_edge_value);
                o_bb_min_x    <= i_bb_min_x;
                o_bb_min_y    <= i_bb_min_y;
                o_bb_max_x    <= i_bb_max_x;
                o_bb_max_y    <= i_bb_max_y;
                r_bb_nonempty <= i_bb_nonempty;
            end
            EDGE0: begin
                o_edge0_val <= to_area(i_edge_value);
                o_edge0_dx  <= to_step(i_edge_step_x);
                o_edge0_dy  <= to_step(i_edge_step_y);
            end
            EDGE1: begin
                o_edge1_val <= to_area(i_edge_value);
                o_edge1_dx  <= to_step(i_edge_step_x);
                o_edge1_dy  <= to_step(i_edge_step_y);
            end
            EDGE2: begin
                o_edge2_val <= to_area(i_edge_value);
                o_edge2_dx  <= to_step(i_edge_step_x);
                o_edge2_dy  <= to_step(i_edge_step_y);
            end
            default: begin
            end
        endcase
    end

endmodule

/* hw/triangle_setup.sv */
`timescale 1ns/1ps

module triangle_setup (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_valid,
    output logic               o_ready,
    input  raster_pkg::coord_t i_v0_x,
    input  raster_pkg::coord_t i_v0_y,
    input  raster_pkg::coord_t i_v1_x,
    input  raster_pkg::coord_t i_v1_y,
    input  raster_pkg::coord_t i_v2_x,
    input  raster_pkg::coord_t i_v2_y,
    output logic               o_valid,
    input  logic               i_ready,
    output logic               o_culled,
    output raster_pkg::coord_t o_bb_min_x,
    output raster_pkg::coord_t o_bb_min_y,
    output raster_pkg::coord_t o_bb_max_x,
    output raster_pkg::coord_t o_bb_max_y,
    output raster_pkg::area_t  o_area,
    output raster_pkg::area_t  o_edge0_val,
    output raster_pkg::area_t  o_edge1_val,
    output raster_pkg::area_t  o_edge2_val,
    output raster_pkg::area_t  o_edge0_dx,
    output raster_pkg::area_t  o_edge0_dy,
    output raster_pkg::area_t  o_edge1_dx,
    output raster_pkg::area_t  o_edge1_dy,
    output raster_pkg::area_t  o_edge2_dx,
    output raster_pkg::area_t  o_edge2_dy
);
    import raster_pkg::*;

    // Shared edge unit operands and results
    coord_t edge_a_x, edge_a_y;
    coord_t edge_b_x, edge_b_y;
    coord_t edge_p_x, edge_p_y;
    wide_t  edge_value;
    coord_t edge_step_x, edge_step_y;

    // Registered vertices and the box computed from them
    coord_t vtx0_x, vtx0_y;
    coord_t vtx1_x, vtx1_y;
    coord_t vtx2_x, vtx2_y;
    coord_t bb_min_x, bb_min_y;
    coord_t bb_max_x, bb_max_y;
    logic   bb_nonempty;

    // Handshake and result ports match the top by name
    setup_ctrl u_ctrl (
        .o_edge_a_x    (edge_a_x),
        .o_edge_a_y    (edge_a_y),
        .o_edge_b_x    (edge_b_x),
        .o_edge_b_y    (edge_b_y),
        .o_edge_p_x    (edge_p_x),
        .o_edge_p_y    (edge_p_y),
        .i_edge_value  (edge_value),
        .i_edge_step_x (edge_step_x),
        .i_edge_step_y (edge_step_y),
        .i_bb_min_x    (bb_min_x),
        .i_bb_min_y    (bb_min_y),
        .i_bb_max_x    (bb_max_x),
        .i_bb_max_y    (bb_max_y),
        .i_bb_nonempty (bb_nonempty),
        .o_vtx0_x      (vtx0_x),
        .o_vtx0_y      (vtx0_y),
        .o_vtx1_x      (vtx1_x),
        .o_vtx1_y      (vtx1_y),
        .o_vtx2_x      (vtx2_x),
        .o_vtx2_y      (vtx2_y),
        .*
    );

    edge_function_unit u_edge (
        .i_a_x    (edge_a_x),
        .i_a_y    (edge_a_y),
        .i_b_x    (edge_b_x),
        .i_b_y    (edge_b_y),
        .i_p_x    (edge_p_x),
        .i_p_y    (edge_p_y),
        .o_value  (edge_value),
        .o_step_x (edge_step_x),
        .o_step_y (edge_step_y)
    );

    bbox_clamp u_bbox (
        .i_v0_x     (vtx0_x),
        .i_v0_y     (vtx0_y),
        .i_v1_x     (vtx1_x),
        .i_v1_y     (vtx1_y),
        .i_v2_x     (vtx2_x),
        .i_v2_y     (vtx2_y),
        .o_min_x    (bb_min_x),
        .o_min_y    (bb_min_y),
        .o_max_x    (bb_max_x),
        .o_max_y    (bb_max_y),
        .o_nonempty (bb_nonempty)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the triangle setup testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_triangle_setup \
    -f triangle_setup.f

./obj_dir/Vtb_triangle_setup | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "run_sim: simulation passed"
    exit 0
else
    echo "run_sim: simulation failed"
    exit 1
fi

/* testbench/setup_ctrl_checker.sv */
`timescale 1ns/1ps

module setup_ctrl_checker (
    input logic                     clk,
    input logic                     rstn,
    input raster_pkg::setup_state_e i_state,
    input logic                     i_in_ready,
    input logic                     i_out_valid
);
    import raster_pkg::*;

    // Input side is open only while idle
    a_ready_idle: assert property (@(posedge clk) disable iff (!rstn)
        i_in_ready == (i_state == IDLE))
        else $error("o_ready does not track the IDLE state");

    a_from_idle: assert property (@(posedge clk) disable iff (!rstn)
        (i_state == IDLE) |=> (i_state == IDLE || i_state == AREA))
        else $error("illegal transition out of IDLE");

    a_from_area: assert property (@(posedge clk) disable iff (!rstn)
        (i_state == AREA) |=> (i_state == EDGE0))
        else $error("illegal transition out of AREA");

    // Culled triangles skip the last two edges
    a_from_edge0: assert property (@(posedge clk) disable iff (!rstn)
        (i_state == EDGE0) |=> (i_state == EDGE1 || i_state == DONE))
        else $error("illegal transition out of EDGE0");

    a_from_edge1: assert property (@(posedge clk) disable iff (!rstn)
        (i_state == EDGE1) |=> (i_state == EDGE2))
        else $error("illegal transition out of EDGE1");

    a_from_edge2: assert property (@(posedge clk) disable iff (!rstn)
        (i_state == EDGE2) |=> (i_state == DONE))
        else $error("illegal transition out of EDGE2");

    a_from_done: assert property (@(posedge clk) disable iff (!rstn)
        (i_state == DONE) |=> (i_state == DONE || i_state == IDLE))
        else $error("illegal transition out of DONE");

    a_valid_done: assert property (@(posedge clk) disable iff (!rstn)
        i_out_valid |-> (i_state == DONE))
        else $error("o_valid high outside DONE");

endmodule

bind setup_ctrl setup_ctrl_checker u_checker (
    .clk         (clk),
    .rstn        (rstn),
    .i_state     (state),
    .i_in_ready  (o_ready),
    .i_out_valid (o_valid)
);

/* testbench/tb_triangle_setup.sv */
`timescale 1ns/1ps

`include "raster_macros.svh"

module tb_triangle_setup;
    import raster_pkg::*;

    localparam int ONE = 1 << `RASTER_FRAC_BITS;
    localparam int SCREEN_X = `RASTER_SCREEN_W * ONE;
    localparam int SCREEN_Y = `RASTER_SCREEN_H * ONE;
    localparam int PROD_DROP = 2 * `RASTER_FRAC_BITS - `RASTER_AREA_FRAC_BITS;
    localparam int STEP_DROP = `RASTER_FRAC_BITS - `RASTER_AREA_FRAC_BITS;
    localparam int ONE_PIXEL_AREA = 1 << `RASTER_AREA_FRAC_BITS;
    localparam int TIMEOUT = 40;
    localparam int RANDOM_TRIANGLES = 80;

    logic   clk, rstn, i_valid, o_ready, o_valid, i_ready, o_culled;
    coord_t i_v0_x, i_v0_y, i_v1_x, i_v1_y, i_v2_x, i_v2_y;
    coord_t o_bb_min_x, o_bb_min_y, o_bb_max_x, o_bb_max_y;
    area_t  o_area, o_edge0_val, o_edge1_val, o_edge2_val;
    area_t  o_edge0_dx, o_edge0_dy, o_edge1_dx, o_edge1_dy, o_edge2_dx, o_edge2_dy;

    logic [449:0] out_bus;
    logic [449:0] held;

    int   vx[3];
    int   vy[3];
    int   exp_min_x, exp_min_y, exp_max_x, exp_max_y, exp_area;
    int   exp_val[3];
    int   exp_dx[3];
    int   exp_dy[3];
    logic exp_culled;
    int   errors, timeouts, checks, kept, culled;
    int   n;

    triangle_setup u_dut (.*);

    assign out_bus = {o_valid, o_culled, o_bb_min_x, o_bb_min_y, o_bb_max_x, o_bb_max_y,
                      o_area, o_edge0_val, o_edge1_val, o_edge2_val, o_edge0_dx, o_edge0_dy,
                      o_edge1_dx, o_edge1_dy, o_edge2_dx, o_edge2_dy};

    always #50 clk = ~clk;

    // Edge function of a->b at p cut from Q32.32 to Q28.4
    function automatic int edge_q4(int ax, int ay, int bx, int by, int px, int py);
        longint prod;
        prod = longint'(px - ax) * longint'(by - ay) - longint'(py - ay) * longint'(bx - ax);
        return int'(prod >>> PROD_DROP);
    endfunction

    function automatic int smallest(int a, int b, int c);
        int m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic int largest(int a, int b, int c);
        int m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    task automatic predict();
        int e;
        int b;
        exp_min_x = smallest(vx[0], vx[1], vx[2]);
        exp_min_y = smallest(vy[0], vy[1], vy[2]);
        exp_max_x = largest(vx[0], vx[1], vx[2]);
        exp_max_y = largest(vy[0], vy[1], vy[2]);
        exp_min_x = (exp_min_x < 0) ? 0 : exp_min_x;
        exp_min_y = (exp_min_y < 0) ? 0 : exp_min_y;
        exp_max_x = (exp_max_x > SCREEN_X) ? SCREEN_X : exp_max_x;
        exp_max_y = (exp_max_y > SCREEN_Y) ? SCREEN_Y : exp_max_y;
        exp_area = edge_q4(vx[0], vy[0], vx[1], vy[1], vx[2], vy[2]);
        // Edges sampled at the clamped top-left corner
        for (e = 0; e < 3; e++) begin
            b = (e + 1) % 3;
            exp_val[e] = edge_q4(vx[e], vy[e], vx[b], vy[b], exp_min_x, exp_min_y);
            exp_dx[e] = (vy[b] - vy[e]) >>> STEP_DROP;
            exp_dy[e] = (vx[e] - vx[b]) >>> STEP_DROP;
        end
        exp_culled = (exp_area <= ONE_PIXEL_AREA) ||
                     !(exp_min_x < exp_max_x && exp_min_y < exp_max_y);
    endtask

    task automatic check_word(string name, int expected, int actual);
        checks++;
        assert (actual == expected) else begin
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_results();
        check_word("o_culled", int'(exp_culled), int'(o_culled));
        check_word("o_bb_min_x", exp_min_x, o_bb_min_x);
        check_word("o_bb_min_y", exp_min_y, o_bb_min_y);
        check_word("o_bb_max_x", exp_max_x, o_bb_max_x);
        check_word("o_bb_max_y", exp_max_y, o_bb_max_y);
        check_word("o_area", exp_area, o_area);
        check_word("o_edge0_val", exp_val[0], o_edge0_val);
        check_word("o_edge0_dx", exp_dx[0], o_edge0_dx);
        check_word("o_edge0_dy", exp_dy[0], o_edge0_dy);
        // Edges 1 and 2 are skipped for culled triangles
        if (!exp_culled) begin
            check_word("o_edge1_val", exp_val[1], o_edge1_val);
            check_word("o_edge1_dx", exp_dx[1], o_edge1_dx);
            check_word("o_edge1_dy", exp_dy[1], o_edge1_dy);
            check_word("o_edge2_val", exp_val[2], o_edge2_val);
            check_word("o_edge2_dx", exp_dx[2], o_edge2_dx);
            check_word("o_edge2_dy", exp_dy[2], o_edge2_dy);
        end
    endtask

    task automatic set_triangle(int x0, int y0, int x1, int y1, int x2, int y2);
        vx[0] = x0 * ONE;
        vy[0] = y0 * ONE;
        vx[1] = x1 * ONE;
        vy[1] = y1 * ONE;
        vx[2] = x2 * ONE;
        vy[2] = y2 * ONE;
    endtask

    task automatic random_triangle();
        int k;
        for (k = 0; k < 3; k++) begin
            vx[k] = (int'($urandom % 768) - 64) * ONE + int'($urandom % 65536);
            vy[k] = (int'($urandom % 488) - 64) * ONE + int'($urandom % 65536);
        end
    endtask

    // want_culled of -1 leaves the cull decision to the model alone
    task automatic run_triangle(int want_culled);
        int   cycles;
        int   hold;
        logic seen_ready;
        predict();
        i_v0_x = vx[0];
        i_v0_y = vy[0];
        i_v1_x = vx[1];
        i_v1_y = vy[1];
        i_v2_x = vx[2];
        i_v2_y = vy[2];
        i_valid = 1'b1;
        cycles = 0;
        seen_ready = 1'b0;
        while (!seen_ready && cycles < TIMEOUT) begin
            seen_ready = o_ready;
            @(posedge clk);
            #5;
            cycles++;
        end
        i_valid = 1'b0;
        if (!seen_ready) begin
            $display("Timeout: the DUT never accepted a triangle");
            timeouts++;
            return;
        end
        cycles = 0;
        while (!o_valid && cycles < TIMEOUT) begin
            @(posedge clk);
            #5;
            cycles++;
        end
        if (!o_valid) begin
            $display("Timeout: no output beat after an accepted triangle");
            timeouts++;
            return;
        end
        check_word("o_valid latency", exp_culled ? 3 : 5, cycles);
        check_results();
        if (want_culled >= 0) begin
            check_word("o_culled", want_culled, int'(o_culled));
        end
        if (exp_culled) begin
            culled++;
        end else begin
            kept++;
        end
        held = out_bus;
        hold = int'($urandom % 4);
        repeat (hold) begin
            @(posedge clk);
            #5;
            checks++;
            assert (out_bus == held) else begin
                $display("FAIL %0t result outputs expected %h actual %h", $time, held, out_bus);
                errors++;
            end
            check_word("o_ready", 0, int'(o_ready));
        end
        i_ready = 1'b1;
        @(posedge clk);
        #5;
        i_ready = 1'b0;
        check_word("o_valid", 0, int'(o_valid));
        check_word("o_ready", 1, int'(o_ready));
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        i_valid = 1'b0;
        i_ready = 1'b0;
        {i_v0_x, i_v0_y, i_v1_x, i_v1_y, i_v2_x, i_v2_y} = '0;
        errors = 0;
        timeouts = 0;
        checks = 0;
        kept = 0;
        culled = 0;
        void'($urandom(32'h0dd4_ee38));
        repeat (10) @(posedge clk);
        #5;
        rstn = 1'b1;
        check_word("o_valid", 0, int'(o_valid));
        check_word("o_culled", 0, int'(o_culled));
        check_word("o_ready", 1, int'(o_ready));

        set_triangle(0, 0, 0, 10, 10, 0);
        run_triangle(0);
        // Clockwise winding
        set_triangle(0, 0, 10, 0, 0, 10);
        run_triangle(1);
        // Collinear sliver
        set_triangle(100, 100, 200, 200, 300, 300);
        run_triangle(1);
        // Thin sliver with exactly one pixel of area
        set_triangle(100, 100, 200, 201, 101, 101);
        run_triangle(1);
        // Same sliver just above the cull threshold
        set_triangle(100, 100, 200, 201, 102, 102);
        run_triangle(0);
        // Counter-clockwise but fully left of and above the screen
        set_triangle(-50, -50, -40, -20, -10, -45);
        run_triangle(1);
        // Right of the screen while y stays on screen
        set_triangle(650, 10, 700, 100, 680, 20);
        run_triangle(1);
        set_triangle(10, 10, 20, 300, 600, 50);
        run_triangle(0);

        for (n = 0; n < RANDOM_TRIANGLES && timeouts == 0; n++) begin
            random_triangle();
            run_triangle(-1);
        end

        $display("Checks %0d, errors %0d, timeouts %0d, kept %0d, culled %0d",
                 checks, errors, timeouts, kept, culled);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* triangle_setup.f */
+incdir+common
common/raster_pkg.sv
hw/edge_function_unit.sv
hw/bbox_clamp.sv
hw/setup_ctrl.sv
hw/triangle_setup.sv
testbench/setup_ctrl_checker.sv
testbench/tb_triangle_setup.sv
